// ==== sim/fsc_testdata.txt ====
// columns: command, argument a, argument b, all hex
// 1 write a=reg b=data, 2 read a=reg b=expected, 3 sync with no frame, 4 sync and frame a=ready mode, 5 soft reset out a=expected, 0 end
// reset defaults
5 0 0
2 0 00000000
2 1 00100008
2 2 00000000
2 3 00000000
2 4 00000000
2 5 00000000
2 6 00100008
2 7 00000000
2 8 00000000
2 9 00000000
2 a 00000000
2 b 00000000
2 f 00000000
// overlapping stream windows, junk in unused bits
1 1 f00cf006
1 2 00010002
1 3 00080005
1 4 00020001
1 5 00080005
1 7 00030000
1 8 00060004
1 9 00060003
1 a 00060004
1 b 12345678
2 1 000c0006
2 2 00010002
2 4 00020001
2 9 00060003
2 a 00060004
2 b 00000000
// frame sync while soft reset is low
3 0 0
1 0 fffffff1
2 0 00000001
5 1 0
4 0 0
// configuring holds the old geometry
1 0 00000003
2 0 00000003
1 9 00010002
1 5 00040002
4 1 0
1 0 00000001
4 0 0
4 1 0
0 0 0

// ==== verilog.f ====
hdl/fsc_pkg.sv
hdl/fsc_host_port.sv
hdl/fsc_regbank.sv
hdl/fsc_frame_commit.sv
hdl/fsc_raster.sv
hdl/fsc_layer_sel.sv
hdl/fsc_top.sv
sim/tb_clkgen.sv
sim/tb_fsc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fsc_top -f verilog.f \
	-Mdir obj_dir -o tb_fsc_top > build.log 2>&1 || { cat build.log; exit 1; }

./obj_dir/tb_fsc_top > sim.log 2>&1
cat sim.log

grep -q "Testbench failed" sim.log && exit 1 || grep -q "Testbench passed" sim.log

// ==== sim/tb_fsc_top.sv ====
`timescale 1ns/100ps

module tb_fsc_top
	import fsc_pkg::*;
();

	localparam int FRAME_W      = 16;
	localparam int FRAME_H      = 8;
	localparam int FRAME_PIX    = FRAME_W * FRAME_H;
	localparam int RESET_CYCLES = 16;
	localparam int TAIL_CYCLES  = 20;
	localparam int CMD_WORDS    = 192;

	// command codes of the test data file
	localparam logic [31:0] CMD_END   = 32'd0;
	localparam logic [31:0] CMD_WRITE = 32'd1;
	localparam logic [31:0] CMD_READ  = 32'd2;
	localparam logic [31:0] CMD_IDLE  = 32'd3;
	localparam logic [31:0] CMD_FRAME = 32'd4;
	localparam logic [31:0] CMD_SOFT  = 32'd5;

	localparam logic [DATA_W-1:0] GEOM_MASK = 32'h0FFF_0FFF;
	localparam logic [DATA_W-1:0] DEF_SIZE  = {4'h0, 12'(FRAME_W), 4'h0, 12'(FRAME_H)};

	logic              o_clk;
	logic              o_resetn;
	logic              i_host_req_valid;
	host_req_t         i_host_req;
	logic              o_host_ack;
	logic [DATA_W-1:0] o_host_rdata;
	logic              i_fsync;
	logic              o_fsync;
	logic              o_soft_resetn;
	logic              o_pix_valid;
	pix_t              o_pix;
	logic              i_pix_ready;

	logic [31:0]       cmd_mem [0:CMD_WORDS-1];
	int                cmd_total;
	int                error_count;
	logic [31:0]       rng_state;

	// reference model, host copy and active copy per stream
	logic [DATA_W-1:0] pend_reg [1:2][0:4];
	logic [DATA_W-1:0] act_reg [1:2][0:4];
	logic              model_cfging;

	tb_clkgen #(
		.HALF_PERIOD  (10),
		.RESET_CYCLES (RESET_CYCLES)
	) i_clkgen (
		.o_clk    (o_clk),
		.o_resetn (o_resetn)
	);

	fsc_top #(
		.IMG_WDEF (FRAME_W),
		.IMG_HDEF (FRAME_H)
	) i_dut (
		.i_clk            (o_clk),
		.i_resetn         (o_resetn),
		.i_host_req_valid (i_host_req_valid),
		.i_host_req       (i_host_req),
		.o_host_ack       (o_host_ack),
		.o_host_rdata     (o_host_rdata),
		.i_fsync          (i_fsync),
		.o_fsync          (o_fsync),
		.o_soft_resetn    (o_soft_resetn),
		.o_pix_valid      (o_pix_valid),
		.o_pix            (o_pix),
		.i_pix_ready      (i_pix_ready)
	);

	// ----------------------------------------
	// reporting
	// ----------------------------------------
	task automatic stop_run();
		error_count++;
		$display("Testbench failed");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic string pix_text(input pix_t p);
		return $sformatf("x=%0d y=%0d layer=%0d src=(%0d,%0d) start=%b line_end=%b end=%b",
			p.x, p.y, p.layer, p.src_x, p.src_y, p.frame_start, p.line_end, p.frame_end);
	endfunction

	task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
				  input logic [DATA_W-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %08h actual %08h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_layer(input string name, input layer_e exp, input layer_e act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %s actual %s", name, exp.name(), act.name());
			stop_run();
		end
	endtask

	task automatic check_pix(input string name, input pix_t exp, input pix_t act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %s actual %s", name, pix_text(exp), pix_text(act));
			stop_run();
		end
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic int field_hi(input logic [DATA_W-1:0] w);
		return int'(w[16 +: IMG_WBITS]);
	endfunction

	function automatic int field_lo(input logic [DATA_W-1:0] w);
		return int'(w[0 +: IMG_HBITS]);
	endfunction

	task automatic model_reset();
		int s;
		int i;
		model_cfging = 1'b0;
		for (s = 1; s <= 2; s++) begin
			for (i = 0; i < 5; i++) begin
				pend_reg[s][i] = (i == 0) ? DEF_SIZE : '0;
				act_reg[s][i] = (i == 0) ? DEF_SIZE : '0;
			end
		end
	endtask

	task automatic model_write(input int a, input logic [DATA_W-1:0] d);
		if (a == 0)
			model_cfging = d[1];
		else if (a >= 1 && a <= 10)
			pend_reg[(a - 1) / 5 + 1][(a - 1) % 5] = d & GEOM_MASK;
	endtask

	// the frame sync edge copies geometry unless the host is configuring
	task automatic model_commit();
		int s;
		int i;
		if (!model_cfging) begin
			for (s = 1; s <= 2; s++)
				for (i = 0; i < 5; i++)
					act_reg[s][i] = pend_reg[s][i];
		end
	endtask

	function automatic pix_t expected_pixel(input int x, input int y);
		pix_t p;
		int   s;
		int   dl;
		int   dt;
		p.x = IMG_WBITS'(x);
		p.y = IMG_HBITS'(y);
		p.layer = LAYER_S0;
		p.src_x = IMG_WBITS'(x);
		p.src_y = IMG_HBITS'(y);
		// stream 2 checked last so it wins an overlap
		for (s = 1; s <= 2; s++) begin
			dl = field_hi(act_reg[s][3]);
			dt = field_lo(act_reg[s][3]);
			if (x >= dl && x < dl + field_hi(act_reg[s][4]) &&
			    y >= dt && y < dt + field_lo(act_reg[s][4])) begin
				p.layer = (s == 2) ? LAYER_S2 : LAYER_S1;
				p.src_x = IMG_WBITS'(field_hi(act_reg[s][1]) + x - dl);
				p.src_y = IMG_HBITS'(field_lo(act_reg[s][1]) + y - dt);
			end
		end
		p.frame_start = (x == 0) && (y == 0);
		p.line_end = (x == FRAME_W - 1);
		p.frame_end = (x == FRAME_W - 1) && (y == FRAME_H - 1);
		return p;
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// ----------------------------------------
	// bus drivers
	// ----------------------------------------
	task automatic host_access(input host_op_e op, input reg_addr_e addr,
				   input logic [DATA_W-1:0] data,
				   output logic [DATA_W-1:0] rdata);
		host_req_t req;
		req.op = op;
		req.addr = addr;
		req.wdata = data;
		@(posedge o_clk);
		i_host_req <= req;
		i_host_req_valid <= 1'b1;
		do
			@(negedge o_clk);
		while (!o_host_ack);
		rdata = o_host_rdata;
		@(posedge o_clk);
		i_host_req_valid <= 1'b0;
		do
			@(negedge o_clk);
		while (o_host_ack);
	endtask

	task automatic pulse_fsync(input string name);
		int wait_cycles;
		wait_cycles = 0;
		@(posedge o_clk);
		i_fsync <= 1'b1;
		model_commit();
		do begin
			@(negedge o_clk);
			wait_cycles++;
		end while (!o_fsync && wait_cycles < 8);
		if (!o_fsync) begin
			$display("%s: no committed frame sync after the fsync edge", name);
			stop_run();
		end
		@(posedge o_clk);
		i_fsync <= 1'b0;
	endtask

	task automatic expect_no_pixels(input string name, input int cycles);
		repeat (cycles) begin
			@(negedge o_clk);
			if (o_pix_valid) begin
				$display("%s: pixel output when none was expected", name);
				stop_run();
			end
		end
	endtask

	// mode 0 keeps the sink ready, mode 1 draws ready at random
	task automatic run_frame(input int mode, input string name);
		int   count;
		int   x;
		int   y;
		pix_t exp_pix;
		count = 0;
		pulse_fsync(name);
		while (count < FRAME_PIX) begin
			@(posedge o_clk);
			if (mode != 0) begin
				rng_state = xorshift32(rng_state);
				i_pix_ready <= rng_state[4];
			end else begin
				i_pix_ready <= 1'b1;
			end
			@(negedge o_clk);
			if (o_pix_valid && i_pix_ready) begin
				x = count % FRAME_W;
				y = count / FRAME_W;
				exp_pix = expected_pixel(x, y);
				check_layer($sformatf("%s layer of pixel %0d", name, count),
					exp_pix.layer, o_pix.layer);
				check_pix($sformatf("%s pixel %0d", name, count), exp_pix, o_pix);
				count++;
			end
		end
		@(posedge o_clk);
		i_pix_ready <= 1'b1;
		expect_no_pixels($sformatf("%s after frame end", name), TAIL_CYCLES);
	endtask

	// ----------------------------------------
	// watchdog
	// ----------------------------------------
	initial begin
		wait (cmd_total != 0);
		repeat (RESET_CYCLES + cmd_total * 4 * (FRAME_PIX + 50)) @(posedge o_clk);
		$display("watchdog: the test commands did not finish in time");
		stop_run();
	end

	// ----------------------------------------
	// command sequencer
	// ----------------------------------------
	initial begin
		int                n;
		logic [31:0]       op;
		logic [31:0]       arg_a;
		logic [31:0]       arg_b;
		logic [DATA_W-1:0] rdata;
		string             name;

		i_host_req_valid = 1'b0;
		i_host_req = '0;
		i_fsync = 1'b0;
		i_pix_ready = 1'b1;
		error_count = 0;
		rng_state = 32'd35;
		cmd_total = 0;
		model_reset();

		for (n = 0; n < CMD_WORDS; n++)
			cmd_mem[n] = '0;
		$readmemh("sim/fsc_testdata.txt", cmd_mem);
		while (3 * cmd_total < CMD_WORDS && cmd_mem[3 * cmd_total] != CMD_END)
			cmd_total++;
		if (cmd_total == 0) begin
			$display("no commands found in the test data file");
			stop_run();
		end

		wait (o_resetn === 1'b1);
		repeat (2) @(posedge o_clk);

		for (n = 0; n < cmd_total; n++) begin
			op = cmd_mem[3 * n];
			arg_a = cmd_mem[3 * n + 1];
			arg_b = cmd_mem[3 * n + 2];
			case (op)
				CMD_WRITE: begin
					host_access(OP_WRITE, reg_addr_e'(arg_a[3:0]), arg_b, rdata);
					model_write(int'(arg_a[3:0]), arg_b);
				end
				CMD_READ: begin
					name = $sformatf("cmd %0d read reg %0d", n, arg_a[3:0]);
					host_access(OP_READ, reg_addr_e'(arg_a[3:0]), '0, rdata);
					check_word(name, arg_b, rdata);
				end
				CMD_IDLE: begin
					name = $sformatf("cmd %0d sync under soft reset", n);
					pulse_fsync(name);
					expect_no_pixels(name, FRAME_PIX + TAIL_CYCLES);
				end
				CMD_FRAME: begin
					name = $sformatf("cmd %0d frame ready mode %0d", n, arg_a);
					run_frame(int'(arg_a), name);
				end
				CMD_SOFT: begin
					name = $sformatf("cmd %0d soft reset output", n);
					@(negedge o_clk);
					check_word(name, arg_a, DATA_W'(o_soft_resetn));
				end
				default: begin
					$display("cmd %0d has an unknown command code %0h", n, op);
					stop_run();
				end
			endcase
		end

		if (error_count == 0) begin
			$display("Testbench passed");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/100ps

module tb_clkgen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 16
) (
	output logic o_clk,
	output logic o_resetn
);

	initial begin
		o_clk = 1'b0;
		forever #(HALF_PERIOD) o_clk = ~o_clk;
	end

	// synchronous reset, released on a rising edge
	initial begin
		o_resetn = 1'b0;
		repeat (RESET_CYCLES) @(posedge o_clk);
		o_resetn <= 1'b1;
	end

endmodule

// ==== hdl/fsc_top.sv ====
`timescale 1ns/100ps

module fsc_top
	import fsc_pkg::*;
#(
	parameter int IMG_WDEF = 320,
	parameter int IMG_HDEF = 240
) (
	input  logic              i_clk,
	input  logic              i_resetn,
	input  logic              i_host_req_valid,
	input  host_req_t         i_host_req,
	output logic              o_host_ack,
	output logic [DATA_W-1:0] o_host_rdata,
	input  logic              i_fsync,
	output logic              o_fsync,
	output logic              o_soft_resetn,
	output logic              o_pix_valid,
	output pix_t              o_pix,
	input  logic              i_pix_ready
);

	// ----------------------------------------
	// internal nets
	// ----------------------------------------
	logic                 rd_en;
	logic                 wr_en;
	reg_addr_e            addr;
	logic [DATA_W-1:0]    wdata;
	logic [DATA_W-1:0]    rd_data;
	ctrl_t                ctrl;
	stream_geom_t         pend_s1;
	stream_geom_t         pend_s2;
	stream_geom_t         act_s1;
	stream_geom_t         act_s2;
	logic                 fsync_commit;
	logic                 raster_valid;
	logic [IMG_WBITS-1:0] raster_x;
	logic [IMG_HBITS-1:0] raster_y;
	logic                 raster_frame_start;
	logic                 raster_line_end;
	logic                 raster_frame_end;
	logic                 stall;

	// both pipeline stages hold while the sink is not ready
	assign stall = o_pix_valid && !i_pix_ready;
	assign o_fsync = fsync_commit;

	fsc_host_port i_host_port (
		.i_clk       (i_clk),
		.i_resetn    (i_resetn),
		.i_req_valid (i_host_req_valid),
		.i_req       (i_host_req),
		.o_ack       (o_host_ack),
		.o_rdata     (o_host_rdata),
		.o_rd_en     (rd_en),
		.o_wr_en     (wr_en),
		.o_addr      (addr),
		.o_wdata     (wdata),
		.i_rd_data   (rd_data)
	);

	fsc_regbank #(
		.IMG_WDEF (IMG_WDEF),
		.IMG_HDEF (IMG_HDEF)
	) i_regbank (
		.i_clk     (i_clk),
		.i_resetn  (i_resetn),
		.i_rd_en   (rd_en),
		.i_wr_en   (wr_en),
		.i_addr    (addr),
		.i_wdata   (wdata),
		.o_rd_data (rd_data),
		.o_ctrl    (ctrl),
		.o_pend_s1 (pend_s1),
		.o_pend_s2 (pend_s2)
	);

	fsc_frame_commit #(
		.IMG_WDEF (IMG_WDEF),
		.IMG_HDEF (IMG_HDEF)
	) i_frame_commit (
		.i_clk          (i_clk),
		.i_resetn       (i_resetn),
		.i_fsync        (i_fsync),
		.i_ctrl         (ctrl),
		.i_pend_s1      (pend_s1),
		.i_pend_s2      (pend_s2),
		.o_fsync_commit (fsync_commit),
		.o_soft_resetn  (o_soft_resetn),
		.o_act_s1       (act_s1),
		.o_act_s2       (act_s2)
	);

	fsc_raster #(
		.IMG_WDEF (IMG_WDEF),
		.IMG_HDEF (IMG_HDEF)
	) i_raster (
		.i_clk         (i_clk),
		.i_resetn      (i_resetn),
		.i_start       (fsync_commit),
		.i_enable      (o_soft_resetn),
		.i_stall       (stall),
		.o_valid       (raster_valid),
		.o_x           (raster_x),
		.o_y           (raster_y),
		.o_frame_start (raster_frame_start),
		.o_line_end    (raster_line_end),
		.o_frame_end   (raster_frame_end)
	);

	fsc_layer_sel #(
		.IMG_WDEF (IMG_WDEF),
		.IMG_HDEF (IMG_HDEF)
	) i_layer_sel (
		.i_clk         (i_clk),
		.i_resetn      (i_resetn),
		.i_valid       (raster_valid),
		.i_x           (raster_x),
		.i_y           (raster_y),
		.i_frame_start (raster_frame_start),
		.i_line_end    (raster_line_end),
		.i_frame_end   (raster_frame_end),
		.i_stall       (stall),
		.i_act_s1      (act_s1),
		.i_act_s2      (act_s2),
		.o_valid       (o_pix_valid),
		.o_pix         (o_pix)
	);

endmodule

// ==== hdl/fsc_layer_sel.sv ====
`timescale 1ns/100ps

module fsc_layer_sel
	import fsc_pkg::*;
#(
	parameter int IMG_WDEF = 320,
	parameter int IMG_HDEF = 240
) (
	input  logic                 i_clk,
	input  logic                 i_resetn,
	input  logic                 i_valid,
	input  logic [IMG_WBITS-1:0] i_x,
	input  logic [IMG_HBITS-1:0] i_y,
	input  logic                 i_frame_start,
	input  logic                 i_line_end,
	input  logic                 i_frame_end,
	input  logic                 i_stall,
	input  stream_geom_t         i_act_s1,
	input  stream_geom_t         i_act_s2,
	output logic                 o_valid,
	output pix_t                 o_pix
);

	// stream 0 fills the output frame one to one
	localparam stream_geom_t S0_GEOM = '{
		width:      IMG_WBITS'(IMG_WDEF),
		height:     IMG_HBITS'(IMG_HDEF),
		win_width:  IMG_WBITS'(IMG_WDEF),
		win_height: IMG_HBITS'(IMG_HDEF),
		dst_width:  IMG_WBITS'(IMG_WDEF),
		dst_height: IMG_HBITS'(IMG_HDEF),
		default:    '0
	};

	layer_e       sel_layer;
	stream_geom_t sel_geom;
	pix_t         next_pix;

	// left and top edges inside, right and bottom edges outside
	function automatic logic geom_hit(input stream_geom_t g,
					  input logic [IMG_WBITS-1:0] x,
					  input logic [IMG_HBITS-1:0] y);
		logic [IMG_WBITS:0] x_end;
		logic [IMG_HBITS:0] y_end;
		x_end = {1'b0, g.dst_left} + {1'b0, g.dst_width};
		y_end = {1'b0, g.dst_top} + {1'b0, g.dst_height};
		return (x >= g.dst_left) && ({1'b0, x} < x_end) &&
		       (y >= g.dst_top) && ({1'b0, y} < y_end);
	endfunction

	// ----------------------------------------
	// priority select, s2 over s1 over s0
	// ----------------------------------------
	always_comb begin
		if (geom_hit(i_act_s2, i_x, i_y)) begin
			sel_layer = LAYER_S2;
			sel_geom = i_act_s2;
		end else if (geom_hit(i_act_s1, i_x, i_y)) begin
			sel_layer = LAYER_S1;
			sel_geom = i_act_s1;
		end else begin
			sel_layer = LAYER_S0;
			sel_geom = S0_GEOM;
		end
	end

	always_comb begin
		next_pix.x = i_x;
		next_pix.y = i_y;
		next_pix.layer = sel_layer;
		// window origin plus offset into the destination, no scaling
		next_pix.src_x = sel_geom.win_left + (i_x - sel_geom.dst_left);
		next_pix.src_y = sel_geom.win_top + (i_y - sel_geom.dst_top);
		next_pix.frame_start = i_frame_start;
		next_pix.line_end = i_line_end;
		next_pix.frame_end = i_frame_end;
	end

	always_ff @(posedge i_clk) begin
		if (!i_resetn)
			o_valid <= 1'b0;
		else if (!i_stall)
			o_valid <= i_valid;
	end

	always_ff @(posedge i_clk) begin
		if (!i_stall && i_valid)
			o_pix <= next_pix;
	end

endmodule

// ==== hdl/fsc_raster.sv ====
`timescale 1ns/100ps

module fsc_raster
	import fsc_pkg::*;
#(
	parameter int IMG_WDEF = 320,
	parameter int IMG_HDEF = 240
) (
	input  logic                 i_clk,
	input  logic                 i_resetn,
	input  logic                 i_start,
	input  logic                 i_enable,
	input  logic                 i_stall,
	output logic                 o_valid,
	output logic [IMG_WBITS-1:0] o_x,
	output logic [IMG_HBITS-1:0] o_y,
	output logic                 o_frame_start,
	output logic                 o_line_end,
	output logic                 o_frame_end
);

	logic running;
	logic last_x;
	logic last_y;

	assign last_x = (o_x == IMG_WBITS'(IMG_WDEF - 1));
	assign last_y = (o_y == IMG_HBITS'(IMG_HDEF - 1));

	assign o_valid = running;
	assign o_frame_start = (o_x == '0) && (o_y == '0);
	assign o_line_end = last_x;
	assign o_frame_end = last_x && last_y;

	always_ff @(posedge i_clk) begin
		if (!i_resetn) begin
			running <= 1'b0;
			o_x <= '0;
			o_y <= '0;
		end else if (!i_enable) begin
			// scan-out held idle under soft reset
			running <= 1'b0;
		end else if (i_start) begin
			running <= 1'b1;
			o_x <= '0;
			o_y <= '0;
		end else if (running && !i_stall) begin
			if (last_x) begin
				o_x <= '0;
				if (last_y)
					running <= 1'b0;
				else
					o_y <= o_y + 1'b1;
			end else begin
				o_x <= o_x + 1'b1;
			end
		end
	end

endmodule

// ==== hdl/fsc_frame_commit.sv ====
`timescale 1ns/100ps

module fsc_frame_commit
	import fsc_pkg::*;
#(
	parameter int IMG_WDEF = 320,
	parameter int IMG_HDEF = 240
) (
	input  logic         i_clk,
	input  logic         i_resetn,
	input  logic         i_fsync,
	input  ctrl_t        i_ctrl,
	input  stream_geom_t i_pend_s1,
	input  stream_geom_t i_pend_s2,
	output logic         o_fsync_commit,
	output logic         o_soft_resetn,
	output stream_geom_t o_act_s1,
	output stream_geom_t o_act_s2
);

	logic fsync_s;
	logic fsync_d;
	logic fsync_rise;

	// ----------------------------------------
	// frame sync edge
	// ----------------------------------------
	always_ff @(posedge i_clk) begin
		if (!i_resetn) begin
			fsync_s <= 1'b0;
			fsync_d <= 1'b0;
		end else begin
			fsync_s <= i_fsync;
			fsync_d <= fsync_s;
		end
	end

	assign fsync_rise = fsync_s && !fsync_d;

	always_ff @(posedge i_clk) begin
		if (!i_resetn) begin
			o_fsync_commit <= 1'b0;
			o_soft_resetn <= 1'b0;
		end else begin
			o_fsync_commit <= fsync_rise;
			o_soft_resetn <= i_ctrl.soft_resetn;
		end
	end

	// ----------------------------------------
	// shadow copy
	// ----------------------------------------
	// geometry only moves at a frame boundary, and not while the host
	// is halfway through a set of updates
	always_ff @(posedge i_clk) begin
		if (!i_resetn) begin
			o_act_s1 <= geom_default(IMG_WDEF, IMG_HDEF);
			o_act_s2 <= geom_default(IMG_WDEF, IMG_HDEF);
		end else if (fsync_rise && !i_ctrl.display_cfging) begin
			o_act_s1 <= i_pend_s1;
			o_act_s2 <= i_pend_s2;
		end
	end

endmodule

// ==== hdl/fsc_regbank.sv ====
`timescale 1ns/100ps

module fsc_regbank
	import fsc_pkg::*;
#(
	parameter int IMG_WDEF = 320,
	parameter int IMG_HDEF = 240
) (
	input  logic              i_clk,
	input  logic              i_resetn,
	input  logic              i_rd_en,
	input  logic              i_wr_en,
	input  reg_addr_e         i_addr,
	input  logic [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rd_data,
	output ctrl_t             o_ctrl,
	output stream_geom_t      o_pend_s1,
	output stream_geom_t      o_pend_s2
);

	// width in the upper half word, height in the lower
	localparam int W_LSB = 16;
	localparam int H_LSB = 0;

	logic [DATA_W-1:0] rd_mux;
	logic              s1_sel;
	logic              s2_sel;
	logic [2:0]        s1_idx;
	logic [2:0]        s2_idx;

	// ----------------------------------------
	// register layout helpers
	// ----------------------------------------
	function automatic logic [DATA_W-1:0] pack_pair(input logic [IMG_WBITS-1:0] w,
							 input logic [IMG_HBITS-1:0] h);
		logic [DATA_W-1:0] word;
		word = '0;
		word[W_LSB +: IMG_WBITS] = w;
		word[H_LSB +: IMG_HBITS] = h;
		return word;
	endfunction

	// idx is the register offset within one stream block
	function automatic logic [DATA_W-1:0] geom_word(input stream_geom_t g,
							 input logic [2:0] idx);
		case (idx)
			3'd0: return pack_pair(g.width, g.height);
			3'd1: return pack_pair(g.win_left, g.win_top);
			3'd2: return pack_pair(g.win_width, g.win_height);
			3'd3: return pack_pair(g.dst_left, g.dst_top);
			3'd4: return pack_pair(g.dst_width, g.dst_height);
			default: return '0;
		endcase
	endfunction

	function automatic stream_geom_t geom_update(input stream_geom_t g,
						    input logic [2:0] idx,
						    input logic [DATA_W-1:0] d);
		logic [IMG_WBITS-1:0] w;
		logic [IMG_HBITS-1:0] h;
		stream_geom_t         n;
		w = d[W_LSB +: IMG_WBITS];
		h = d[H_LSB +: IMG_HBITS];
		n = g;
		case (idx)
			3'd0: begin
				n.width = w;
				n.height = h;
			end
			3'd1: begin
				n.win_left = w;
				n.win_top = h;
			end
			3'd2: begin
				n.win_width = w;
				n.win_height = h;
			end
			3'd3: begin
				n.dst_left = w;
				n.dst_top = h;
			end
			3'd4: begin
				n.dst_width = w;
				n.dst_height = h;
			end
			default: n = g;
		endcase
		return n;
	endfunction

	// ----------------------------------------
	// address decode
	// ----------------------------------------
	assign s1_sel = (i_addr >= REG_S1_SIZE) && (i_addr <= REG_S1_DST_SIZE);
	assign s2_sel = (i_addr >= REG_S2_SIZE) && (i_addr <= REG_S2_DST_SIZE);
	assign s1_idx = 3'(i_addr - REG_S1_SIZE);
	assign s2_idx = 3'(i_addr - REG_S2_SIZE);

	always_ff @(posedge i_clk) begin
		if (!i_resetn) begin
			o_ctrl <= '0;
			o_pend_s1 <= geom_default(IMG_WDEF, IMG_HDEF);
			o_pend_s2 <= geom_default(IMG_WDEF, IMG_HDEF);
		end else if (i_wr_en) begin
			if (i_addr == REG_CTRL) begin
				o_ctrl.soft_resetn <= i_wdata[0];
				o_ctrl.display_cfging <= i_wdata[1];
			end
			if (s1_sel)
				o_pend_s1 <= geom_update(o_pend_s1, s1_idx, i_wdata);
			if (s2_sel)
				o_pend_s2 <= geom_update(o_pend_s2, s2_idx, i_wdata);
		end
	end

	// readback, unused bits and indices as zero
	always_comb begin
		rd_mux = '0;
		if (i_addr == REG_CTRL)
			rd_mux = DATA_W'({o_ctrl.display_cfging, o_ctrl.soft_resetn});
		else if (s1_sel)
			rd_mux = geom_word(o_pend_s1, s1_idx);
		else if (s2_sel)
			rd_mux = geom_word(o_pend_s2, s2_idx);
	end

	assign o_rd_data = i_rd_en ? rd_mux : '0;

endmodule

// ==== hdl/fsc_host_port.sv ====
`timescale 1ns/100ps

module fsc_host_port
	import fsc_pkg::*;
(
	input  logic              i_clk,
	input  logic              i_resetn,
	input  logic              i_req_valid,
	input  host_req_t         i_req,
	output logic              o_ack,
	output logic [DATA_W-1:0] o_rdata,
	output logic              o_rd_en,
	output logic              o_wr_en,
	output reg_addr_e         o_addr,
	output logic [DATA_W-1:0] o_wdata,
	input  logic [DATA_W-1:0] i_rd_data
);

	port_state_e state;
	logic        accept;

	// req sampled while idle starts one handshake
	assign accept = (state == PS_IDLE) && i_req_valid;

	// one strobe per handshake, in the sampling cycle
	assign o_rd_en = accept && (i_req.op == OP_READ);
	assign o_wr_en = accept && (i_req.op == OP_WRITE);

	// host holds request fields until it sees ack
	assign o_addr = i_req.addr;
	assign o_wdata = i_req.wdata;

	always_ff @(posedge i_clk) begin
		if (!i_resetn) begin
			state <= PS_IDLE;
			o_ack <= 1'b0;
		end else begin
			case (state)
				PS_IDLE: begin
					if (i_req_valid) begin
						state <= PS_ACK;
						o_ack <= 1'b1;
					end
				end
				PS_ACK: begin
					state <= PS_WAIT_LOW;
				end
				PS_WAIT_LOW: begin
					// drop ack once req has gone low
					if (!i_req_valid) begin
						state <= PS_IDLE;
						o_ack <= 1'b0;
					end
				end
				default: begin
					state <= PS_IDLE;
					o_ack <= 1'b0;
				end
			endcase
		end
	end

	// read data held for the whole ack phase
	always_ff @(posedge i_clk) begin
		if (o_rd_en)
			o_rdata <= i_rd_data;
	end

endmodule

// ==== hdl/fsc_pkg.sv ====
package fsc_pkg;

	// ----------------------------------------
	// widths
	// ----------------------------------------
	localparam int IMG_WBITS = 12;
	localparam int IMG_HBITS = 12;
	localparam int DATA_W    = 32;
	localparam int ADDR_W    = 4;

	typedef enum logic {
		OP_READ  = 1'b0,
		OP_WRITE = 1'b1
	} host_op_e;

	// register map, indices 11 to 15 unused
	typedef enum logic [ADDR_W-1:0] {
		REG_CTRL        = 4'd0,
		REG_S1_SIZE     = 4'd1,
		REG_S1_WIN_POS  = 4'd2,
		REG_S1_WIN_SIZE = 4'd3,
		REG_S1_DST_POS  = 4'd4,
		REG_S1_DST_SIZE = 4'd5,
		REG_S2_SIZE     = 4'd6,
		REG_S2_WIN_POS  = 4'd7,
		REG_S2_WIN_SIZE = 4'd8,
		REG_S2_DST_POS  = 4'd9,
		REG_S2_DST_SIZE = 4'd10
	} reg_addr_e;

	typedef enum logic [1:0] {
		PS_IDLE     = 2'd0,
		PS_ACK      = 2'd1,
		PS_WAIT_LOW = 2'd2
	} port_state_e;

	typedef enum logic [1:0] {
		LAYER_S0 = 2'd0,
		LAYER_S1 = 2'd1,
		LAYER_S2 = 2'd2
	} layer_e;

	// ----------------------------------------
	// structs
	// ----------------------------------------
	typedef struct packed {
		host_op_e          op;
		reg_addr_e         addr;
		logic [DATA_W-1:0] wdata;
	} host_req_t;

	typedef struct packed {
		logic [IMG_WBITS-1:0] width;
		logic [IMG_HBITS-1:0] height;
		logic [IMG_WBITS-1:0] win_left;
		logic [IMG_HBITS-1:0] win_top;
		logic [IMG_WBITS-1:0] win_width;
		logic [IMG_HBITS-1:0] win_height;
		logic [IMG_WBITS-1:0] dst_left;
		logic [IMG_HBITS-1:0] dst_top;
		logic [IMG_WBITS-1:0] dst_width;
		logic [IMG_HBITS-1:0] dst_height;
	} stream_geom_t;

	typedef struct packed {
		logic soft_resetn;
		logic display_cfging;
	} ctrl_t;

	typedef struct packed {
		logic [IMG_WBITS-1:0] x;
		logic [IMG_HBITS-1:0] y;
		layer_e               layer;
		logic [IMG_WBITS-1:0] src_x;
		logic [IMG_HBITS-1:0] src_y;
		logic                 frame_start;
		logic                 line_end;
		logic                 frame_end;
	} pix_t;

	// source size set, every other field zero
	function automatic stream_geom_t geom_default(input int w, input int h);
		stream_geom_t g;
		g = '0;
		g.width = IMG_WBITS'(w);
		g.height = IMG_HBITS'(h);
		return g;
	endfunction

endpackage
